//--- hw/st_source_cfg.svh
// --------------------------------------
// configuration macros for the streaming
// packet source: field widths, entry queue
// depth, ready latency, ready delay line
// and latency response width
// --------------------------------------
`ifndef ST_SOURCE_CFG_SVH
`define ST_SOURCE_CFG_SVH

// symbol layout of one data word
`define ST_SYMBOL_W        8
`define ST_NUM_SYMBOLS     4
`define ST_DATA_W          (`ST_SYMBOL_W * `ST_NUM_SYMBOLS)

// packet side fields
`define ST_CHANNEL_W       4
`define ST_EMPTY_W         2
`define ST_IDLE_W          16

// queue depth, also the credit count held by upstream
`define ST_QUEUE_DEPTH     8

// ready latency, legal range 0 to 3
`define ST_READY_LATENCY   1
`define ST_MAX_READY_DELAY 4

// back-pressure latency response width
`define ST_LATENCY_W       16

`endif

//--- hw/st_source_pkg.sv
// --------------------------------------
// shared types of the streaming source
//   beat struct, idle-run struct
//   entry union and tagged queue entry
// --------------------------------------
`default_nettype none

`include "st_source_cfg.svh"

package st_source_pkg;

   // one streaming beat as it leaves the source
   typedef struct packed {
      logic                     sop;
      logic                     eop;
      logic [`ST_CHANNEL_W-1:0] channel;
      logic [`ST_EMPTY_W-1:0]   empty;
      logic [`ST_DATA_W-1:0]    data;
   } st_beat_t;

   // idle run, padded up to the beat size
   // count sits in the low bits of the word
   typedef struct packed {
      logic [$bits(st_beat_t)-`ST_IDLE_W-1:0] pad;
      logic [`ST_IDLE_W-1:0]                  count;
   } st_idle_t;

   // one payload word, read as a beat or as an idle run
   typedef union packed {
      st_beat_t beat;
      st_idle_t idle;
   } st_entry_u;

   // queue entry: tag selects the union view
   typedef struct packed {
      logic      is_idle;
      st_entry_u payload;
   } st_entry_t;

endpackage

`default_nettype wire

//--- hw/st_beat_if.sv
// --------------------------------------
// beat bus between the driver, the
// latency monitor and the top level
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface st_beat_if;

   // beat presented on the stream this cycle
   logic                   valid;
   st_source_pkg::st_beat_t beat;
   // head beat done with its idle run, waiting for ready
   logic                   pending;
   // beat taken by the sink this cycle
   logic                   accept;

   modport driver (
      output valid,
      output beat,
      output pending,
      output accept
   );

   modport monitor (
      input valid,
      input beat,
      input pending,
      input accept
   );

endinterface

`default_nettype wire

//--- hw/st_entry_queue.sv
// --------------------------------------
// entry FIFO of the streaming source
//   circular buffer with occupancy count
//   one credit pulse back per pop
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module st_entry_queue (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       cmd_valid,
   input  st_source_pkg::st_entry_t  cmd_entry,
   input  wire                       pop,
   output st_source_pkg::st_entry_t  head,
   output logic                      head_valid,
   output logic                      cmd_credit
);

   localparam int DEPTH = `ST_QUEUE_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   st_source_pkg::st_entry_t mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          wr_en;
   logic          rd_en;

   assign full       = (count == (AW+1)'(DEPTH));
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];

   // a pop frees the slot in the same cycle
   assign rd_en = pop & head_valid;
   assign wr_en = cmd_valid & (~full | rd_en);

   // storage, no reset on the entries
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= cmd_entry;
      end
   end

   // pointers, count and credit return
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         cmd_credit <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // occupancy only moves when exactly one side is active
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // credit goes back in the cycle after the pop
         cmd_credit <= rd_en;
      end
   end

endmodule

`default_nettype wire

//--- hw/st_beat_driver.sv
// --------------------------------------
// beat driver of the streaming source
//   pops entries and decodes the union
//   counts down idle runs
//   ready delay line and stream handshake
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module st_beat_driver (
   input  wire                      clk,
   input  wire                      reset,
   input  st_source_pkg::st_entry_t head,
   input  wire                      head_valid,
   input  wire                      out_ready,
   output logic                     pop,
   st_beat_if.driver                beat_bus
);

   localparam int RL  = `ST_READY_LATENCY;
   localparam int MRD = `ST_MAX_READY_DELAY;

   // current entry, held until accepted or idle run is over
   st_source_pkg::st_entry_t cur;
   logic                     cur_valid;
   logic [`ST_IDLE_W-1:0]    idle_cnt;
   logic                     idle_last;

   // ready history, bit 0 is last cycle's ready
   logic [MRD-1:0]           ready_dly;
   logic                     ready_q;

   logic                     pending;
   logic                     valid;
   logic                     accept;

   // --------------------------------------
   // ready delay line
   // --------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_dly <= '0;
      end else begin
         ready_dly <= {ready_dly[MRD-2:0], out_ready};
      end
   end

   // qualified ready: raw ready at latency 0, else stage L-1
   assign ready_q = (RL == 0) ? out_ready : ready_dly[(RL == 0) ? 0 : RL - 1];

   // --------------------------------------
   // handshake
   // --------------------------------------
   // beat entries only, idle runs never pend
   assign pending = cur_valid & ~cur.is_idle;

   // latency 0: valid held until ready
   // latency > 0: valid only where ready was seen L cycles back
   assign valid  = pending & ((RL == 0) | ready_q);
   // both cases reduce to pending and qualified ready
   assign accept = pending & ready_q;

   // fetch the next entry once the slot is free
   assign pop = ~cur_valid & head_valid;

   // idle run ends in the cycle its count reaches one
   assign idle_last = (idle_cnt <= `ST_IDLE_W'(1));

   // --------------------------------------
   // entry hold and idle countdown
   // --------------------------------------
   always_ff @(posedge clk) begin
      if (pop) begin
         cur <= head;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cur_valid <= 1'b0;
         idle_cnt  <= '0;
      end else if (pop) begin
         cur_valid <= 1'b1;
         // idle view of the incoming word
         idle_cnt  <= head.payload.idle.count;
      end else if (cur_valid) begin
         if (cur.is_idle) begin
            if (idle_last) begin
               cur_valid <= 1'b0;
            end else begin
               idle_cnt <= idle_cnt - 1'b1;
            end
         end else if (accept) begin
            cur_valid <= 1'b0;
         end
      end
   end

   // --------------------------------------
   // beat bus, outputs low when not valid
   // --------------------------------------
   assign beat_bus.valid   = valid;
   assign beat_bus.beat    = valid ? cur.payload.beat : '0;
   assign beat_bus.pending = pending;
   assign beat_bus.accept  = accept;

endmodule

`default_nettype wire

//--- hw/st_latency_monitor.sv
// --------------------------------------
// back-pressure latency monitor
//   counts stalled cycles of the beat
//   one response per accepted beat
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module st_latency_monitor (
   input  wire                       clk,
   input  wire                       reset,
   st_beat_if.monitor                beat_bus,
   output logic                      rsp_valid,
   output logic [`ST_LATENCY_W-1:0]  rsp_latency
);

   logic [`ST_LATENCY_W-1:0] stall_cnt;
   logic                     stalled;

   // pending but not taken means ready was low this cycle
   assign stalled = beat_bus.pending & ~beat_bus.accept;

   // --------------------------------------
   // stall counter, saturates at full scale
   // --------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stall_cnt <= '0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= beat_bus.accept;
         if (beat_bus.accept) begin
            stall_cnt <= '0;
         end else if (stalled && stall_cnt != '1) begin
            stall_cnt <= stall_cnt + 1'b1;
         end
      end
   end

   // response value, only meaningful with rsp_valid
   always_ff @(posedge clk) begin
      if (beat_bus.accept) begin
         rsp_latency <= stall_cnt;
      end
   end

endmodule

`default_nettype wire

//--- hw/st_source.sv
// --------------------------------------
// streaming packet source, top level
//   entry queue with credit return
//   beat driver and latency monitor
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module st_source (
   input  wire                                            clk,
   input  wire                                            reset,
   // command side, credit based
   input  wire                                            cmd_valid,
   input  wire                                            cmd_is_idle,
   input  wire  [$bits(st_source_pkg::st_entry_u)-1:0]    cmd_word,
   output logic                                           cmd_credit,
   // stream side
   output logic                                           out_valid,
   output logic                                           out_sop,
   output logic                                           out_eop,
   output logic [`ST_CHANNEL_W-1:0]                       out_channel,
   output logic [`ST_EMPTY_W-1:0]                         out_empty,
   output logic [`ST_DATA_W-1:0]                          out_data,
   input  wire                                            out_ready,
   // response side, no back-pressure
   output logic                                           rsp_valid,
   output logic [`ST_LATENCY_W-1:0]                       rsp_latency
);

   st_source_pkg::st_entry_t cmd_entry;
   st_source_pkg::st_entry_t head;
   logic                     head_valid;
   logic                     pop;

   st_beat_if beat_bus ();

   // tag plus raw payload word into one entry
   assign cmd_entry.is_idle = cmd_is_idle;
   assign cmd_entry.payload = cmd_word;

   st_entry_queue u_queue (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_entry  (cmd_entry),
      .pop        (pop),
      .head       (head),
      .head_valid (head_valid),
      .cmd_credit (cmd_credit)
   );

   st_beat_driver u_driver (
      .clk        (clk),
      .reset      (reset),
      .head       (head),
      .head_valid (head_valid),
      .out_ready  (out_ready),
      .pop        (pop),
      .beat_bus   (beat_bus)
   );

   st_latency_monitor u_monitor (
      .clk         (clk),
      .reset       (reset),
      .beat_bus    (beat_bus),
      .rsp_valid   (rsp_valid),
      .rsp_latency (rsp_latency)
   );

   // beat bus out to the pins, already low when idle
   assign out_valid   = beat_bus.valid;
   assign out_sop     = beat_bus.beat.sop;
   assign out_eop     = beat_bus.beat.eop;
   assign out_channel = beat_bus.beat.channel;
   assign out_empty   = beat_bus.beat.empty;
   assign out_data    = beat_bus.beat.data;

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// --------------------------------------
// testbench clock and reset
//   20 ns period, reset held 4 cycles
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // release away from the rising edge
   initial begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- verif/st_source_checker.sv
// --------------------------------------
// stream checker
//   beat order and fields, idle gaps
//   ready latency rule, latency responses
//   credit pulse count
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module st_source_checker (
   input wire                      clk,
   input wire                      reset,
   input wire                      cmd_valid,
   input wire                      cmd_credit,
   input wire                      out_valid,
   input wire                      out_sop,
   input wire                      out_eop,
   input wire [`ST_CHANNEL_W-1:0]  out_channel,
   input wire [`ST_EMPTY_W-1:0]    out_empty,
   input wire [`ST_DATA_W-1:0]     out_data,
   input wire                      out_ready,
   input wire                      rsp_valid,
   input wire [`ST_LATENCY_W-1:0]  rsp_latency
);

   localparam int RL = `ST_READY_LATENCY;

   int error_count  = 0;
   int beat_count   = 0;
   int rsp_count    = 0;
   int push_count   = 0;
   int credit_count = 0;
   // invalid cycles since the last accepted beat
   int gap          = 1000000;

   st_source_pkg::st_beat_t exp_beat_q [$];
   int                      exp_gap_q  [$];
   int                      exp_lat_q  [$];
   int                      rsp_lat_q  [$];

   st_source_pkg::st_beat_t got;
   st_source_pkg::st_beat_t want;
   int                      want_gap;
   int                      want_lat;
   logic                    accepted;
   // out_ready of earlier cycles, bit 0 is the last one
   logic [3:0]              ready_hist;

   // lat below zero means the latency is not checked
   task automatic expect_beat(input st_source_pkg::st_beat_t b, input int lat,
                              input int min_gap);
      exp_beat_q.push_back(b);
      exp_lat_q.push_back(lat);
      exp_gap_q.push_back(min_gap);
   endtask

   task automatic report_error(input string msg);
      $display("error @%0t: %s", $time, msg);
      error_count++;
   endtask

   // ----------------------------------------
   // per-cycle checks on the rising edge
   // ----------------------------------------
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_hist <= '0;
      end else begin
         if (cmd_valid) push_count++;
         if (cmd_credit) credit_count++;
         if (!out_valid) begin
            if (out_sop || out_eop || out_channel != 0 || out_empty != 0 || out_data != 0)
               report_error("stream outputs not low while out_valid is low");
            gap++;
         end
         // valid only where ready was high L cycles back
         if (RL > 0 && out_valid && !ready_hist[(RL == 0) ? 0 : RL - 1])
            report_error("out_valid high without ready in the latency window");
         accepted = out_valid && (RL > 0 || out_ready);
         if (accepted) begin
            got = {out_sop, out_eop, out_channel, out_empty, out_data};
            if (exp_beat_q.size() == 0) begin
               report_error($sformatf("unexpected beat data %h", out_data));
            end else begin
               want     = exp_beat_q.pop_front();
               want_gap = exp_gap_q.pop_front();
               rsp_lat_q.push_back(exp_lat_q.pop_front());
               if (got != want)
                  report_error($sformatf("beat %0d got %h expected %h",
                                         beat_count, got, want));
               if (gap < want_gap)
                  report_error($sformatf("beat %0d gap %0d shorter than idle run %0d",
                                         beat_count, gap, want_gap));
            end
            beat_count++;
            gap = 0;
         end
         if (rsp_valid) begin
            if (rsp_lat_q.size() == 0) begin
               report_error("latency response without an accepted beat");
            end else begin
               want_lat = rsp_lat_q.pop_front();
               if (want_lat >= 0 && int'(rsp_latency) != want_lat)
                  report_error($sformatf("response %0d latency %0d expected %0d",
                                         rsp_count, rsp_latency, want_lat));
            end
            rsp_count++;
         end
         ready_hist <= {ready_hist[2:0], out_ready};
      end
   end

   // end of run accounting
   task automatic final_check();
      if (exp_beat_q.size() != 0)
         report_error($sformatf("%0d expected beats never came out", exp_beat_q.size()));
      if (rsp_lat_q.size() != 0)
         report_error($sformatf("%0d latency responses missing", rsp_lat_q.size()));
      if (credit_count != push_count)
         report_error($sformatf("%0d credits returned for %0d entries pushed",
                                credit_count, push_count));
   endtask

endmodule

`default_nettype wire

//--- verif/st_source_properties.sv
// --------------------------------------
// handshake assertions bound to st_source
//   credit use, idle outputs low
//   beat held under latency 0 stall
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module st_source_properties (
   input wire                      clk,
   input wire                      reset,
   input wire                      cmd_valid,
   input wire                      cmd_credit,
   input wire                      out_valid,
   input wire                      out_sop,
   input wire                      out_eop,
   input wire [`ST_CHANNEL_W-1:0]  out_channel,
   input wire [`ST_EMPTY_W-1:0]    out_empty,
   input wire [`ST_DATA_W-1:0]     out_data,
   input wire                      out_ready
);

   localparam int RL = `ST_READY_LATENCY;

   // credits held by upstream as tracked from the pins
   int credits;
   // failed assertions so far, read by the testbench top
   int fail_count = 0;

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         credits <= `ST_QUEUE_DEPTH;
      end else begin
         credits <= credits - int'(cmd_valid) + int'(cmd_credit);
      end
   end

   // a credit returned this cycle may be spent right away
   assert property (@(posedge clk) disable iff (reset)
      cmd_valid |-> (credits > 0 || cmd_credit))
      else begin
         fail_count++;
         $error("cmd_valid asserted with no credit left");
      end

   assert property (@(posedge clk) disable iff (reset)
      !out_valid |-> (!out_sop && !out_eop && out_channel == 0 &&
                      out_empty == 0 && out_data == 0))
      else begin
         fail_count++;
         $error("stream outputs not low while idle");
      end

   assert property (@(posedge clk) disable iff (reset)
      (RL == 0 && out_valid && !out_ready) |=>
         (out_valid && $stable(out_data) && $stable(out_channel) &&
          $stable(out_empty) && $stable(out_sop) && $stable(out_eop)))
      else begin
         fail_count++;
         $error("beat changed while stalled");
      end

endmodule

bind st_source st_source_properties u_props (.*);

`default_nettype wire

//--- verif/tb_st_source.sv
// --------------------------------------
// testbench top for st_source
//   golden file records, credit tracking
//   ready patterns and watchdog
// --------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "st_source_cfg.svh"

module tb_st_source;

   localparam int RL           = `ST_READY_LATENCY;
   localparam int DEPTH        = `ST_QUEUE_DEPTH;
   localparam int MAX_RECORDS  = 64;
   localparam int WORST_CYCLES = 80;
   localparam int MARGIN       = 400;

   logic                                  clk;
   logic                                  reset;
   logic                                  cmd_valid;
   logic                                  cmd_is_idle;
   logic [$bits(st_source_pkg::st_entry_u)-1:0] cmd_word;
   logic                                  cmd_credit;
   logic                                  out_valid;
   logic                                  out_sop;
   logic                                  out_eop;
   logic [`ST_CHANNEL_W-1:0]              out_channel;
   logic [`ST_EMPTY_W-1:0]                out_empty;
   logic [`ST_DATA_W-1:0]                 out_data;
   logic                                  out_ready;
   logic                                  rsp_valid;
   logic [`ST_LATENCY_W-1:0]              rsp_latency;

   // kind, arg, expected latency, payload
   logic [63:0] golden [0:MAX_RECORDS-1];
   int          num_records = 0;
   int          credits;
   int          beats_pushed;
   int          idle_since_beat;
   // ready pattern 0 high, 1 random, 2 low
   int          ready_mode;
   int          stall_left;
   logic [31:0] lcg_state;

   tb_clk_gen u_clk_gen (.clk(clk), .reset(reset));

   st_source u_st_source (
      .clk(clk), .reset(reset),
      .cmd_valid(cmd_valid), .cmd_is_idle(cmd_is_idle), .cmd_word(cmd_word),
      .cmd_credit(cmd_credit),
      .out_valid(out_valid), .out_sop(out_sop), .out_eop(out_eop),
      .out_channel(out_channel), .out_empty(out_empty), .out_data(out_data),
      .out_ready(out_ready),
      .rsp_valid(rsp_valid), .rsp_latency(rsp_latency)
   );

   st_source_checker u_checker (
      .clk(clk), .reset(reset),
      .cmd_valid(cmd_valid), .cmd_credit(cmd_credit),
      .out_valid(out_valid), .out_sop(out_sop), .out_eop(out_eop),
      .out_channel(out_channel), .out_empty(out_empty), .out_data(out_data),
      .out_ready(out_ready),
      .rsp_valid(rsp_valid), .rsp_latency(rsp_latency)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // advance one falling edge and update credits, command and ready
   task automatic step_cycle();
      @(negedge clk);
      if (cmd_credit) credits++;
      cmd_valid = 1'b0;
      if (stall_left > 0) begin
         out_ready = 1'b0;
         stall_left--;
      end else if (ready_mode == 0) begin
         out_ready = 1'b1;
      end else if (ready_mode == 1) begin
         lcg_state = lcg_next(lcg_state);
         // about three cycles in four ready
         out_ready = |lcg_state[17:16];
      end else begin
         out_ready = 1'b0;
      end
   endtask

   task automatic push_entry(input logic is_idle, input logic [39:0] word);
      step_cycle();
      while (credits == 0) step_cycle();
      cmd_valid   = 1'b1;
      cmd_is_idle = is_idle;
      cmd_word    = word;
      credits--;
   endtask

   task automatic push_beat(input logic [39:0] word, input int lat);
      u_checker.expect_beat(word, lat, idle_since_beat);
      idle_since_beat = 0;
      beats_pushed++;
      push_entry(1'b0, word);
   endtask

   // all credits back, all responses seen, idle runs over
   task automatic drain_source();
      step_cycle();
      while (credits != DEPTH || u_checker.rsp_count != beats_pushed) step_cycle();
      repeat (16) step_cycle();
   endtask

   // ready low over the first k pending cycles of a lone beat
   task automatic run_stalled_beat(input int k, input int lat, input logic [39:0] word);
      int low_edges;
      low_edges = k + 1 - RL;
      drain_source();
      ready_mode = 2;
      repeat (4) step_cycle();
      push_beat(word, lat);
      repeat (low_edges) step_cycle();
      ready_mode = 0;
      step_cycle();
   endtask

   initial begin
      int lat;
      cmd_valid       = 1'b0;
      cmd_is_idle     = 1'b0;
      cmd_word        = '0;
      out_ready       = 1'b1;
      credits         = DEPTH;
      beats_pushed    = 0;
      idle_since_beat = 0;
      ready_mode      = 0;
      stall_left      = 0;
      lcg_state       = 32'd7820;
      for (int i = 0; i < MAX_RECORDS; i++) golden[i] = '1;
      $readmemh("verif/st_source_golden.txt", golden);
      while (num_records < MAX_RECORDS && golden[num_records][63:56] != 8'hff)
         num_records++;
      if (num_records == 0) begin
         $display("golden file holds no records");
         $display("Simulation failed");
         $finish;
      end
      @(negedge reset);
      for (int i = 0; i < num_records; i++) begin
         lat = (golden[i][47:40] == 8'hff) ? -1 : int'(golden[i][47:40]);
         case (golden[i][63:56])
            8'h00: push_beat(golden[i][39:0], lat);
            8'h01: begin
               idle_since_beat += int'(golden[i][15:0]);
               push_entry(1'b1, golden[i][39:0]);
            end
            8'h02: run_stalled_beat(int'(golden[i][55:48]), lat, golden[i][39:0]);
            8'h03: ready_mode = int'(golden[i][55:48]);
            default: stall_left = int'(golden[i][55:48]);
         endcase
      end
      ready_mode = 0;
      drain_source();
      u_checker.final_check();
      $display("checks finished: %0d beats, %0d responses, %0d errors, %0d assertion failures",
               u_checker.beat_count, u_checker.rsp_count, u_checker.error_count,
               u_st_source.u_props.fail_count);
      if (u_checker.error_count == 0 && u_st_source.u_props.fail_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog sized from the record count
   initial begin
      wait (num_records > 0);
      repeat (num_records * WORST_CYCLES + MARGIN) @(posedge clk);
      $display("watchdog expired, the run did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/st_source_golden.txt
// kind(2) arg(2) latency(2, ff unchecked) payload(10): sop eop channel empty data
// kind 00 beat, 01 idle run, 02 stalled beat (arg k), 03 ready mode, 04 ready low arg cycles
0000008C11223344
0000000C55667788
0000004D99AABBCC
0100000000000005
000000C2DEADBEEF
0301000000000000
0000FF9001020304
0100000000000003
0000FF1005060708
0000FF520A0B0C0D
0203038412345678
020505C487654321
020202C4CAFEF00D
0428000000000000
0000FF8000000001
0000FF0000000002
0000FF0000000003
0000FF0000000004
0000FF0000000005
0000FF0000000006
0000FF0000000007
0000FF0000000008
0000FF4000000009
ff00000000000000

//--- flist.f
+incdir+hw
hw/st_source_pkg.sv
hw/st_beat_if.sv
hw/st_entry_queue.sv
hw/st_beat_driver.sv
hw/st_latency_monitor.sv
hw/st_source.sv
verif/tb_clk_gen.sv
verif/st_source_checker.sv
verif/st_source_properties.sv
verif/tb_st_source.sv

//--- Makefile
# Verilator build and run of the st_source testbench

VERILATOR ?= verilator
TOP       ?= tb_st_source
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST))) hw/st_source_cfg.svh verif/st_source_golden.txt
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
